/* compile.f */
hw/uesprit_pkg.sv
hw/corr_accumulator.sv
hw/corr_scaler.sv
hw/isqrt_seq.sv
hw/eigen_2x2.sv
hw/uesprit_la.sv
sim/uesprit_la_assertions.sv
sim/uesprit_la_tb.sv

/* hw/corr_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module corr_accumulator #(
    parameter int VECTOR_LEN = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  uesprit_pkg::cplx_sample_t din1,
    input  uesprit_pkg::cplx_sample_t din2,
    input  logic                      din_valid,
    input  logic                      new_acc,
    output uesprit_pkg::corr_mat_t    acc_mat,
    output logic                      acc_valid
);

    import uesprit_pkg::*;

    localparam int CNT_W = $clog2(VECTOR_LEN);

    corr_mat_t        prod;
    corr_mat_t        sums;
    logic [CNT_W-1:0] cnt;
    logic             frame_active;
    logic             reload;
    logic             take;
    logic             last_sample;
    logic             frame_done;

    function automatic corr_t mul(input sample_t a, input sample_t b);
        logic signed [31:0] p;
        p = a * b;
        return corr_t'(p);
    endfunction

    // x1*conj(x2) = (ac + bd) + j(bc - ad)
    always_comb begin
        prod.r11    = mul(din1.re, din1.re) + mul(din1.im, din1.im);
        prod.r22    = mul(din2.re, din2.re) + mul(din2.im, din2.im);
        prod.r12_re = mul(din1.re, din2.re) + mul(din1.im, din2.im);
        prod.r12_im = mul(din1.im, din2.re) - mul(din1.re, din2.im);
    end

    // first sample of a frame, either forced or right after a finished one
    assign reload = din_valid && (new_acc || (frame_active && cnt == '0));

    // nothing is taken before the first new_acc
    assign take = din_valid && (new_acc || frame_active);

    assign last_sample = take && !reload && (cnt == CNT_W'(VECTOR_LEN - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_active <= 1'b0;
            cnt          <= '0;
            frame_done   <= 1'b0;
            acc_valid    <= 1'b0;
        end else begin
            frame_done <= last_sample;
            acc_valid  <= frame_done;
            if (reload) begin
                frame_active <= 1'b1;
                cnt          <= CNT_W'(1);
            end else if (last_sample) begin
                cnt <= '0;
            end else if (take) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reload) begin
            sums <= prod;
        end else if (take) begin
            sums.r11    <= sums.r11 + prod.r11;
            sums.r22    <= sums.r22 + prod.r22;
            sums.r12_re <= sums.r12_re + prod.r12_re;
            sums.r12_im <= sums.r12_im + prod.r12_im;
        end
        // old sums are latched even if a new frame reloads on this edge
        if (frame_done) begin
            acc_mat <= sums;
        end
    end

endmodule

`default_nettype wire

/* hw/corr_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module corr_scaler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  uesprit_pkg::corr_mat_t acc_mat,
    input  logic                   acc_valid,
    input  uesprit_pkg::shift_t    shift,
    output uesprit_pkg::la_mat_t   corr,
    output logic                   corr_valid,
    output logic                   corr_sat
);

    import uesprit_pkg::*;

    localparam corr_t LA_MAX = 40'sd32767;
    localparam corr_t LA_MIN = -40'sd32768;

    corr_mat_t shifted;
    la_mat_t   clamped;
    logic      sat_any;

    function automatic logic out_of_range(input corr_t v);
        return (v > LA_MAX) || (v < LA_MIN);
    endfunction

    function automatic la_t clamp(input corr_t v);
        if (v > LA_MAX) begin
            return la_t'(LA_MAX);
        end else if (v < LA_MIN) begin
            return la_t'(LA_MIN);
        end
        return la_t'(v);
    endfunction

    always_comb begin
        shifted.r11    = acc_mat.r11 >>> shift;
        shifted.r22    = acc_mat.r22 >>> shift;
        shifted.r12_re = acc_mat.r12_re >>> shift;
        shifted.r12_im = acc_mat.r12_im >>> shift;

        clamped.r11    = clamp(shifted.r11);
        clamped.r22    = clamp(shifted.r22);
        clamped.r12_re = clamp(shifted.r12_re);
        clamped.r12_im = clamp(shifted.r12_im);

        sat_any = out_of_range(shifted.r11) || out_of_range(shifted.r22) ||
                  out_of_range(shifted.r12_re) || out_of_range(shifted.r12_im);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            corr_valid <= 1'b0;
            corr_sat   <= 1'b0;
        end else begin
            corr_valid <= acc_valid;
            // flag is held with the matrix it belongs to
            if (acc_valid) begin
                corr_sat <= sat_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            corr <= clamped;
        end
    end

endmodule

`default_nettype wire

/* hw/eigen_2x2.sv */
`timescale 1ns/1ps
`default_nettype none

module eigen_2x2 (
    input  logic                     clk,
    input  logic                     rst_n,
    input  uesprit_pkg::la_mat_t     corr,
    input  logic                     corr_valid,
    output uesprit_pkg::eig_result_t eig,
    output logic                     dout_valid
);

    import uesprit_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_disc,
        st_root,
        st_emit
    } state_t;

    state_t             state;
    la_t                r11_q;
    la_t                r22_q;
    la_t                r12_q;
    eig_t               ht;
    eig_t               hd;
    eig_t               ht_q;
    eig_t               s_ext;
    logic signed [33:0] hd_sq;
    logic signed [33:0] r12_sq;
    disc_t              radicand;
    root_t              root;
    logic               start;
    logic               done;
    logic               busy;
    eig_result_t        res;

    // half trace and half difference of the diagonal
    always_comb begin
        ht       = (eig_t'(r11_q) + eig_t'(r22_q)) >>> 1;
        hd       = (eig_t'(r11_q) - eig_t'(r22_q)) >>> 1;
        hd_sq    = hd * hd;
        r12_sq   = r12_q * r12_q;
        radicand = disc_t'(hd_sq + r12_sq);
    end

    assign start = (state == st_disc);
    assign busy  = (state != st_idle);

    isqrt_seq isqrt_seq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .radicand (radicand),
        .start    (start),
        .root     (root),
        .done     (done)
    );

    // lamb = ht +/- s, eigenvectors (r12, lamb - r11) left unnormalized
    always_comb begin
        s_ext        = eig_t'({1'b0, root});
        res.lamb1    = ht_q + s_ext;
        res.lamb2    = ht_q - s_ext;
        res.eigen1_y = ht_q + s_ext - eig_t'(r11_q);
        res.eigen2_y = ht_q - s_ext - eig_t'(r11_q);
        res.eigen_x  = eig_t'(r12_q);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= (state == st_emit);
            case (state)
                st_idle: begin
                    if (corr_valid) begin
                        state <= st_disc;
                    end
                end
                st_disc: state <= st_root;
                st_root: begin
                    if (done) begin
                        state <= st_emit;
                    end
                end
                st_emit: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // r12_im has no part in the real eigenproblem
        if (corr_valid && !busy) begin
            r11_q <= corr.r11;
            r22_q <= corr.r22;
            r12_q <= corr.r12_re;
        end
        if (state == st_disc) begin
            ht_q <= ht;
        end
        if (state == st_emit) begin
            eig <= res;
        end
    end

endmodule

`default_nettype wire

/* hw/isqrt_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module isqrt_seq (
    input  logic               clk,
    input  logic               rst_n,
    input  uesprit_pkg::disc_t radicand,
    input  logic               start,
    output uesprit_pkg::root_t root,
    output logic               done
);

    import uesprit_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t      state;
    logic [33:0] rad_ext;
    logic [33:0] rad_sh;
    logic [19:0] rem;
    logic [4:0]  steps_left;
    root_t       q;

    logic [19:0] rem_in;
    logic [19:0] rem_shift;
    logic [19:0] trial;
    logic [19:0] rem_nxt;
    root_t       q_in;
    root_t       q_nxt;
    logic [1:0]  pair;

    // padded to an even width, two radicand bits per root bit
    assign rad_ext = {1'b0, radicand};

    // the start cycle already resolves the first root bit
    always_comb begin
        if (state == st_idle) begin
            rem_in = '0;
            q_in   = '0;
            pair   = rad_ext[33:32];
        end else begin
            rem_in = rem;
            q_in   = q;
            pair   = rad_sh[33:32];
        end
        rem_shift = {rem_in[17:0], pair};
        trial     = {1'b0, q_in, 2'b01};
        if (rem_shift >= trial) begin
            rem_nxt = rem_shift - trial;
            q_nxt   = {q_in[15:0], 1'b1};
        end else begin
            rem_nxt = rem_shift;
            q_nxt   = {q_in[15:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            steps_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state      <= st_run;
                        steps_left <= 5'd16;
                    end
                end
                st_run: begin
                    steps_left <= steps_left - 1'b1;
                    if (steps_left == 5'd1) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_run) begin
            rem    <= rem_nxt;
            q      <= q_nxt;
            rad_sh <= rad_sh << 2;
        end else if (start) begin
            rem    <= rem_nxt;
            q      <= q_nxt;
            rad_sh <= rad_ext << 2;
        end
    end

    assign root = q;

endmodule

`default_nettype wire

/* hw/uesprit_la.sv */
`timescale 1ns/1ps
`default_nettype none

module uesprit_la #(
    parameter int VECTOR_LEN = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  uesprit_pkg::cplx_sample_t din1,
    input  uesprit_pkg::cplx_sample_t din2,
    input  logic                      din_valid,
    input  logic                      new_acc,
    input  uesprit_pkg::shift_t       shift,
    output uesprit_pkg::la_mat_t      corr,
    output logic                      corr_valid,
    output logic                      corr_sat,
    output uesprit_pkg::eig_result_t  eig,
    output logic                      dout_valid
);

    import uesprit_pkg::*;

    corr_mat_t acc_mat;
    logic      acc_valid;

    corr_accumulator #(
        .VECTOR_LEN (VECTOR_LEN)
    ) corr_accumulator_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din1      (din1),
        .din2      (din2),
        .din_valid (din_valid),
        .new_acc   (new_acc),
        .acc_mat   (acc_mat),
        .acc_valid (acc_valid)
    );

    // scaled matrix goes out and into the solver
    corr_scaler corr_scaler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_mat    (acc_mat),
        .acc_valid  (acc_valid),
        .shift      (shift),
        .corr       (corr),
        .corr_valid (corr_valid),
        .corr_sat   (corr_sat)
    );

    eigen_2x2 eigen_2x2_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .corr       (corr),
        .corr_valid (corr_valid),
        .eig        (eig),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

/* hw/uesprit_pkg.sv */
`default_nettype none

package uesprit_pkg;

    // one signed sample component
    typedef logic signed [15:0] sample_t;

    // accumulated correlation term, 32 bit products plus frame growth
    typedef logic signed [39:0] corr_t;

    // linear algebra input word
    typedef logic signed [15:0] la_t;

    // hd^2 + r12^2, always non-negative
    typedef logic [32:0] disc_t;

    // floor square root of disc_t
    typedef logic [16:0] root_t;

    // eigenvalues and eigenvector components
    typedef logic signed [17:0] eig_t;

    // run-time scaling of the correlation matrix
    typedef logic [4:0] shift_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    typedef struct packed {
        corr_t r11;
        corr_t r22;
        corr_t r12_re;
        corr_t r12_im;
    } corr_mat_t;

    typedef struct packed {
        la_t r11;
        la_t r22;
        la_t r12_re;
        la_t r12_im;
    } la_mat_t;

    typedef struct packed {
        eig_t lamb1;
        eig_t lamb2;
        eig_t eigen1_y;
        eig_t eigen2_y;
        eig_t eigen_x;
    } eig_result_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module uesprit_la_tb -f compile.f -o uesprit_la_tb_sim

out=$(./obj_dir/uesprit_la_tb_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Test OK"

/* sim/uesprit_la_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module uesprit_la_assertions (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic corr_valid,
    input wire logic corr_sat,
    input wire logic dout_valid
);

    // cycles left until the solver is free again
    logic [4:0] pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (corr_valid) begin
            pending <= 5'd19;
        end else if (pending != '0) begin
            pending <= pending - 1'b1;
        end
    end

    solver_latency: assert property (@(posedge clk) disable iff (!rst_n)
        dout_valid == $past(corr_valid, 20))
        else $error("dout_valid does not follow corr_valid by 20 cycles");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        corr_valid |-> pending == '0)
        else $error("corr_valid arrived while a solve was pending");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !corr_valid && !corr_sat && !dout_valid)
        else $error("an output strobe was high right after reset");

endmodule

bind uesprit_la uesprit_la_assertions uesprit_la_assertions_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .corr_valid (corr_valid),
    .corr_sat   (corr_sat),
    .dout_valid (dout_valid)
);

`default_nettype wire

/* sim/uesprit_la_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uesprit_la_tb;

    import uesprit_pkg::*;

    localparam int VECTOR_LEN = 32;
    localparam int N_RANDOM   = 20;
    localparam int JUNK_LEAD  = 7;
    localparam int LATENCY    = 20;

    typedef struct packed {
        shift_t       shift;
        cplx_sample_t x1;
        cplx_sample_t x2;
        la_mat_t      corr;
        logic         sat;
        eig_result_t  eig;
    } file_test_t;

    logic         clk;
    logic         rst_n;
    cplx_sample_t din1;
    cplx_sample_t din2;
    logic         din_valid;
    logic         new_acc;
    shift_t       shift;
    la_mat_t      corr;
    logic         corr_valid;
    logic         corr_sat;
    eig_result_t  eig;
    logic         dout_valid;

    cplx_sample_t frame1 [VECTOR_LEN];
    cplx_sample_t frame2 [VECTOR_LEN];
    file_test_t   file_tests [$];
    string        test_names [$];
    int           cycle_count = 0;
    int           cycle_limit = 100000;
    logic         frame_seen  = 1'b0;

    uesprit_la #(
        .VECTOR_LEN (VECTOR_LEN)
    ) uesprit_la_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din1       (din1),
        .din2       (din2),
        .din_valid  (din_valid),
        .new_acc    (new_acc),
        .shift      (shift),
        .corr       (corr),
        .corr_valid (corr_valid),
        .corr_sat   (corr_sat),
        .eig        (eig),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout: the run took more cycles than the tests need");
        end
    end

    task automatic check_corr(input string name, input la_mat_t exp_m, input logic exp_sat,
                              input la_mat_t act_m, input logic act_sat);
        if (act_m !== exp_m || act_sat !== exp_sat) begin
            abort_run($sformatf(
                "mismatch %s corr: expected %0d %0d %0d %0d sat %0b actual %0d %0d %0d %0d sat %0b",
                name, exp_m.r11, exp_m.r22, exp_m.r12_re, exp_m.r12_im, exp_sat,
                act_m.r11, act_m.r22, act_m.r12_re, act_m.r12_im, act_sat));
        end
    endtask

    task automatic check_eig(input string name, input eig_result_t exp_e,
                             input eig_result_t act_e);
        if (act_e !== exp_e) begin
            abort_run($sformatf(
                "mismatch %s eig: expected %0d %0d %0d %0d %0d actual %0d %0d %0d %0d %0d",
                name, exp_e.lamb1, exp_e.lamb2, exp_e.eigen1_y, exp_e.eigen2_y, exp_e.eigen_x,
                act_e.lamb1, act_e.lamb2, act_e.eigen1_y, act_e.eigen2_y, act_e.eigen_x));
        end
    endtask

    function automatic cplx_sample_t random_sample();
        cplx_sample_t s;
        s.re = sample_t'($urandom);
        s.im = sample_t'($urandom);
        return s;
    endfunction

    function automatic longint floor_sqrt(input longint d);
        longint s;
        s = longint'($floor($sqrt(real'(d))));
        while (s * s > d) begin
            s = s - 1;
        end
        while ((s + 1) * (s + 1) <= d) begin
            s = s + 1;
        end
        return s;
    endfunction

    function automatic la_t clamp_word(input longint v);
        if (v > 32767) begin
            return la_t'(32767);
        end else if (v < -32768) begin
            return la_t'(-32768);
        end
        return la_t'(v);
    endfunction

    function automatic logic word_clamped(input longint v);
        return (v > 32767) || (v < -32768);
    endfunction

    // sums over the frame arrays, then shift and clamp
    task automatic model_matrix(input shift_t sh, output la_mat_t m, output logic sat);
        longint a;
        longint b;
        longint c;
        longint d;
        longint s11;
        longint s22;
        longint s12r;
        longint s12i;
        s11  = 0;
        s22  = 0;
        s12r = 0;
        s12i = 0;
        for (int i = 0; i < VECTOR_LEN; i++) begin
            a = longint'(frame1[i].re);
            b = longint'(frame1[i].im);
            c = longint'(frame2[i].re);
            d = longint'(frame2[i].im);
            s11  += a * a + b * b;
            s22  += c * c + d * d;
            s12r += a * c + b * d;
            s12i += b * c - a * d;
        end
        s11  = s11 >>> sh;
        s22  = s22 >>> sh;
        s12r = s12r >>> sh;
        s12i = s12i >>> sh;
        m.r11    = clamp_word(s11);
        m.r22    = clamp_word(s22);
        m.r12_re = clamp_word(s12r);
        m.r12_im = clamp_word(s12i);
        sat = word_clamped(s11) || word_clamped(s22) ||
              word_clamped(s12r) || word_clamped(s12i);
    endtask

    task automatic model_eigen(input la_mat_t m, output eig_result_t e);
        longint r11;
        longint r22;
        longint r12;
        longint ht;
        longint hd;
        longint s;
        r11 = longint'(m.r11);
        r22 = longint'(m.r22);
        r12 = longint'(m.r12_re);
        ht  = (r11 + r22) >>> 1;
        hd  = (r11 - r22) >>> 1;
        s   = floor_sqrt(hd * hd + r12 * r12);
        e.lamb1    = eig_t'(ht + s);
        e.lamb2    = eig_t'(ht - s);
        e.eigen1_y = eig_t'(ht + s - r11);
        e.eigen2_y = eig_t'(ht - s - r11);
        e.eigen_x  = eig_t'(r12);
    endtask

    task automatic read_tests();
        int                 fd;
        int                 n;
        reg [8*256-1:0]     line;
        reg [8*32-1:0]      name_buf;
        int                 v [15];
        file_test_t         t;
        fd = $fopen("sim/uesprit_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test vector file sim/uesprit_tests.txt");
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            name_buf, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                            v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
                // comment and blank lines do not parse to a full vector
                if (n == 16) begin
                    t.shift       = shift_t'(v[0]);
                    t.x1.re       = sample_t'(v[1]);
                    t.x1.im       = sample_t'(v[2]);
                    t.x2.re       = sample_t'(v[3]);
                    t.x2.im       = sample_t'(v[4]);
                    t.corr.r11    = la_t'(v[5]);
                    t.corr.r22    = la_t'(v[6]);
                    t.corr.r12_re = la_t'(v[7]);
                    t.corr.r12_im = la_t'(v[8]);
                    t.sat         = v[9][0];
                    t.eig.lamb1    = eig_t'(v[10]);
                    t.eig.lamb2    = eig_t'(v[11]);
                    t.eig.eigen1_y = eig_t'(v[12]);
                    t.eig.eigen2_y = eig_t'(v[13]);
                    t.eig.eigen_x  = eig_t'(v[14]);
                    file_tests.push_back(t);
                    test_names.push_back(string'(name_buf));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_sample(input cplx_sample_t a, input cplx_sample_t b,
                                input logic valid, input logic restart);
        @(negedge clk);
        if (corr_valid || dout_valid) begin
            abort_run("a result strobe came before its frame was complete");
        end
        if (corr_sat && !frame_seen) begin
            abort_run("corr_sat was high before the first frame completed");
        end
        din1      = a;
        din2      = b;
        din_valid = valid;
        new_acc   = restart;
    endtask

    // drives one frame from the frame arrays and collects both results
    task automatic run_frame(input string name, input shift_t sh, input logic restart,
                             input logic junk, input logic gaps, output la_mat_t got_corr,
                             output logic got_sat, output eig_result_t got_eig);
        int lat;
        @(negedge clk);
        shift = sh;
        if (junk) begin
            // partial frame that the restart below must discard
            for (int i = 0; i < JUNK_LEAD; i++) begin
                drive_sample(random_sample(), random_sample(), 1'b1, i == 0);
            end
        end
        for (int i = 0; i < VECTOR_LEN; i++) begin
            if (gaps && ($urandom % 4 == 0)) begin
                drive_sample(random_sample(), random_sample(), 1'b0, 1'b0);
            end
            drive_sample(frame1[i], frame2[i], 1'b1, (i == 0) && (restart || junk));
        end
        @(negedge clk);
        din_valid = 1'b0;
        new_acc   = 1'b0;
        do begin
            @(negedge clk);
        end while (!corr_valid);
        got_corr   = corr;
        got_sat    = corr_sat;
        frame_seen = 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (corr_valid) begin
                abort_run("a second corr_valid arrived before the eigen results");
            end
        end while (!dout_valid);
        if (lat != LATENCY) begin
            abort_run($sformatf("mismatch %s latency: expected %0d actual %0d",
                                name, LATENCY, lat));
        end
        got_eig = eig;
    endtask

    initial begin
        la_mat_t     got_corr;
        logic        got_sat;
        eig_result_t got_eig;
        la_mat_t     exp_corr;
        logic        exp_sat;
        eig_result_t exp_eig;
        shift_t      sh;
        int          n_frames;

        rst_n     = 1'b0;
        din1      = '0;
        din2      = '0;
        din_valid = 1'b0;
        new_acc   = 1'b0;
        shift     = '0;
        void'($urandom(32'hf2da13cb));

        read_tests();
        if (file_tests.size() == 0) begin
            abort_run("the test vector file holds no tests");
        end
        n_frames    = file_tests.size() + N_RANDOM;
        cycle_limit = n_frames * (VECTOR_LEN + 40) + n_frames * (VECTOR_LEN + JUNK_LEAD) + 200;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // no frame has started yet, so these are dropped
        repeat (VECTOR_LEN) drive_sample(random_sample(), random_sample(), 1'b1, 1'b0);

        foreach (file_tests[t]) begin
            for (int i = 0; i < VECTOR_LEN; i++) begin
                frame1[i] = file_tests[t].x1;
                frame2[i] = file_tests[t].x2;
            end
            run_frame(test_names[t], file_tests[t].shift, 1'b1, 1'b1, 1'b0,
                      got_corr, got_sat, got_eig);
            check_corr(test_names[t], file_tests[t].corr, file_tests[t].sat,
                       got_corr, got_sat);
            check_eig(test_names[t], file_tests[t].eig, got_eig);
        end

        for (int r = 0; r < N_RANDOM; r++) begin
            sh = shift_t'(15 + $urandom % 10);
            for (int i = 0; i < VECTOR_LEN; i++) begin
                frame1[i] = random_sample();
                frame2[i] = random_sample();
            end
            run_frame($sformatf("random_%0d", r), sh, logic'($urandom % 2), 1'b0, 1'b1,
                      got_corr, got_sat, got_eig);
            model_matrix(sh, exp_corr, exp_sat);
            model_eigen(exp_corr, exp_eig);
            check_corr($sformatf("random_%0d", r), exp_corr, exp_sat, got_corr, got_sat);
            check_eig($sformatf("random_%0d", r), exp_eig, got_eig);
        end

        repeat (3) @(negedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/uesprit_tests.txt */
# name shift x1_re x1_im x2_re x2_im r11 r22 r12_re r12_im sat lamb1 lamb2 eigen1_y eigen2_y eigen_x
# x1 and x2 are held constant over the frame of 32 samples
unit_real 5 100 0 100 0 10000 10000 10000 0 0 20000 0 10000 -10000 10000
zero_disc 5 100 0 0 100 10000 10000 0 -10000 0 10000 10000 0 0 0
neg_r12 5 60 80 -30 0 10000 900 -1800 -2400 0 10343 557 343 -9443 -1800
saturate 3 1000 0 1000 1000 32767 32767 32767 -32768 1 65534 0 32767 -32767 32767
no_shift 0 -7 3 5 -2 1856 928 -1312 32 0 2783 1 927 -1855 -1312
floor_shift 6 3 0 -1 0 4 0 -2 0 0 4 0 0 -4 -2
